// File: source/had_jtag_pkg.sv
`default_nettype none

package had_jtag_pkg;

  // shift register widths
  localparam int IR_WIDTH = 8;
  localparam int DR_WIDTH = 32;

  // fixed pattern loaded into the IR on capture-IR
  localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 8'h01;

  // 16-state 1149.1 controller encoding
  // update states get their own bit (4 for IR, 5 for DR)
  // so the update level is a single flop output for the synchronizer
  typedef enum logic [5:0] {
    TAP_RESET          = 6'b000000,
    TAP_IDLE           = 6'b000001,
    TAP_SELECT_DR_SCAN = 6'b000011,
    TAP_SELECT_IR_SCAN = 6'b000010,
    TAP_CAPTURE_IR     = 6'b000110,
    TAP_SHIFT_IR       = 6'b000100,
    TAP_EXIT1_IR       = 6'b000101,
    TAP_PAUSE_IR       = 6'b001101,
    TAP_EXIT2_IR       = 6'b001111,
    TAP_UPDATE_IR      = 6'b010000,
    TAP_CAPTURE_DR     = 6'b001011,
    TAP_SHIFT_DR       = 6'b001010,
    TAP_EXIT1_DR       = 6'b001000,
    TAP_PAUSE_DR       = 6'b001100,
    TAP_EXIT2_DR       = 6'b001110,
    TAP_UPDATE_DR      = 6'b100000
  } tap_state_e;

endpackage

`default_nettype wire

// File: source/had_dbg_pkg.sv
`default_nettype none

package had_dbg_pkg;

  // ============================================================
  // HACR word
  // ============================================================
  // the same byte is shifted in raw through the IR and
  // then decoded as an access type plus a register select
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      // 1 = read access, 0 = write access
      logic       rw;
      logic [6:0] reg_sel;
    } fld;
  } hacr_u;

  // ============================================================
  // register select codes
  // ============================================================
  // fixed identification word
  localparam logic [6:0] SEL_ID   = 7'd0;
  // debug control register, read and write
  localparam logic [6:0] SEL_CTRL = 7'd1;
  // debug fifo head, a read pops it
  localparam logic [6:0] SEL_FIFO = 7'd2;

  // ============================================================
  // reset values
  // ============================================================
  // default access is a read of the ID word
  localparam logic [7:0]  HACR_RESET = {1'b1, SEL_ID};
  localparam logic [31:0] CTRL_RESET = 32'h0000_0000;

endpackage

`default_nettype wire

// File: source/had_sync_3flop.sv
`timescale 1ns/1ps
`default_nettype none

module had_sync_3flop (
  input  wire sm_clk,
  input  wire cpurst_b,
  input  wire tclk_i,
  input  wire trst_b_i,
  input  wire pulse_i,
  output wire level_o
);

  logic       pulse_q;
  logic       toggle_q;
  logic [2:0] sync_q;

  // tclk side
  // one toggle per rising edge of the update level
  always_ff @(posedge tclk_i or negedge trst_b_i)
  begin
    if (!trst_b_i)
    begin
      pulse_q  <= 1'b0;
      toggle_q <= 1'b0;
    end
    else
    begin
      pulse_q <= pulse_i;
      if (pulse_i && !pulse_q)
        toggle_q <= ~toggle_q;
    end
  end

  // sm_clk side
  // three stages, the first one may go metastable
  always_ff @(posedge sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      sync_q <= 3'b000;
    else
      sync_q <= {sync_q[1:0], toggle_q};
  end

  assign level_o = sync_q[2];

endmodule

`default_nettype wire

// File: source/had_tap_sm.sv
`timescale 1ns/1ps
`default_nettype none

module had_tap_sm
  import had_jtag_pkg::*;
(
  input  wire  sm_clk,
  input  wire  cpurst_b,
  input  wire  tclk_i,
  input  wire  trst_b_i,
  input  wire  tms_i,
  input  wire  tap_en_i,
  input  wire  hacr_rw_i,
  output logic shift_ir_o,
  output logic shift_dr_o,
  output logic capture_ir_o,
  output logic capture_dr_o,
  output logic upd_ir_pulse_o,
  output logic upd_dr_pulse_o,
  output logic tdo_en_o
);

  tap_state_e state_q;
  tap_state_e state_d;
  logic       upd_ir_nxt;
  logic       upd_dr_nxt;
  logic       upd_ir_lvl;
  logic       upd_dr_lvl;
  logic       upd_ir_lvl_q;
  logic       upd_dr_lvl_q;

  // ============================================================
  // TAP controller
  // ============================================================
  always_ff @(posedge tclk_i or negedge trst_b_i)
  begin
    if (!trst_b_i)
      state_q <= TAP_RESET;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    case (state_q)
      TAP_RESET:          state_d = tms_i ? TAP_RESET          : TAP_IDLE;
      TAP_IDLE:           state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_IDLE;
      TAP_SELECT_DR_SCAN: state_d = tms_i ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
      TAP_SELECT_IR_SCAN: state_d = tms_i ? TAP_RESET          : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR:     state_d = tms_i ? TAP_EXIT1_IR       : TAP_SHIFT_IR;
      TAP_SHIFT_IR:       state_d = tms_i ? TAP_EXIT1_IR       : TAP_SHIFT_IR;
      TAP_EXIT1_IR:       state_d = tms_i ? TAP_UPDATE_IR      : TAP_PAUSE_IR;
      TAP_PAUSE_IR:       state_d = tms_i ? TAP_EXIT2_IR       : TAP_PAUSE_IR;
      TAP_EXIT2_IR:       state_d = tms_i ? TAP_UPDATE_IR      : TAP_SHIFT_IR;
      TAP_UPDATE_IR:      state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_IDLE;
      TAP_CAPTURE_DR:     state_d = tms_i ? TAP_EXIT1_DR       : TAP_SHIFT_DR;
      TAP_SHIFT_DR:       state_d = tms_i ? TAP_EXIT1_DR       : TAP_SHIFT_DR;
      TAP_EXIT1_DR:       state_d = tms_i ? TAP_UPDATE_DR      : TAP_PAUSE_DR;
      TAP_PAUSE_DR:       state_d = tms_i ? TAP_EXIT2_DR       : TAP_PAUSE_DR;
      TAP_EXIT2_DR:       state_d = tms_i ? TAP_UPDATE_DR      : TAP_SHIFT_DR;
      TAP_UPDATE_DR:      state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_IDLE;
      default:            state_d = TAP_RESET;
    endcase
    // port disabled, park in reset
    if (!tap_en_i)
      state_d = TAP_RESET;
  end

  // tclk domain strobes for the scan chain
  assign shift_ir_o   = (state_q == TAP_SHIFT_IR);
  assign shift_dr_o   = (state_q == TAP_SHIFT_DR);
  assign capture_ir_o = (state_q == TAP_CAPTURE_IR);
  assign capture_dr_o = (state_q == TAP_CAPTURE_DR);

  // ============================================================
  // update events into sm_clk
  // ============================================================
  // dedicated update bits of the next state
  // so the toggle flips on the edge that enters the update state
  assign upd_ir_nxt = state_d[4];
  assign upd_dr_nxt = state_d[5];

  had_sync_3flop u_sync_ir (
    .sm_clk   (sm_clk),
    .cpurst_b (cpurst_b),
    .tclk_i   (tclk_i),
    .trst_b_i (trst_b_i),
    .pulse_i  (upd_ir_nxt),
    .level_o  (upd_ir_lvl)
  );

  had_sync_3flop u_sync_dr (
    .sm_clk   (sm_clk),
    .cpurst_b (cpurst_b),
    .tclk_i   (tclk_i),
    .trst_b_i (trst_b_i),
    .pulse_i  (upd_dr_nxt),
    .level_o  (upd_dr_lvl)
  );

  // edge detect on the synced toggles
  always_ff @(posedge sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      upd_ir_lvl_q <= 1'b0;
      upd_dr_lvl_q <= 1'b0;
    end
    else
    begin
      upd_ir_lvl_q <= upd_ir_lvl;
      upd_dr_lvl_q <= upd_dr_lvl;
    end
  end

  // one sm_clk cycle per update, used as a plain enable
  assign upd_ir_pulse_o = upd_ir_lvl ^ upd_ir_lvl_q;
  assign upd_dr_pulse_o = upd_dr_lvl ^ upd_dr_lvl_q;

  // tdo driven only while shifting out read data
  // hacr_rw_i is quasi static, it settled long before this shift
  always_ff @(negedge tclk_i or negedge trst_b_i)
  begin
    if (!trst_b_i)
      tdo_en_o <= 1'b0;
    else
      tdo_en_o <= shift_dr_o && hacr_rw_i;
  end

endmodule

`default_nettype wire

// File: source/had_scan_chain.sv
`timescale 1ns/1ps
`default_nettype none

module had_scan_chain
  import had_jtag_pkg::*;
  import had_dbg_pkg::*;
(
  input  wire                tclk_i,
  input  wire                trst_b_i,
  input  wire                tdi_i,
  input  wire                shift_ir_i,
  input  wire                shift_dr_i,
  input  wire                capture_ir_i,
  input  wire                capture_dr_i,
  input  wire [DR_WIDTH-1:0] rd_data_i,
  output logic [IR_WIDTH-1:0] ir_value_o,
  output logic [DR_WIDTH-1:0] dr_value_o,
  output logic               tdo_o
);

  logic [IR_WIDTH-1:0] ir_q;
  logic [DR_WIDTH-1:0] dr_q;

  // ============================================================
  // instruction register
  // ============================================================
  // comes out of reset holding the default HACR
  always_ff @(posedge tclk_i or negedge trst_b_i)
  begin
    if (!trst_b_i)
      ir_q <= HACR_RESET;
    else if (capture_ir_i)
      ir_q <= IR_CAPTURE;
    else if (shift_ir_i)
      // lsb first, tdi enters at the top
      ir_q <= {tdi_i, ir_q[IR_WIDTH-1:1]};
  end

  // ============================================================
  // data register
  // ============================================================
  // capture takes the selected register from the sm_clk side
  always_ff @(posedge tclk_i)
  begin
    if (capture_dr_i)
      dr_q <= rd_data_i;
    else if (shift_dr_i)
      dr_q <= {tdi_i, dr_q[DR_WIDTH-1:1]};
  end

  // last shifted words
  // held until the next capture, sampled on the synced update
  assign ir_value_o = ir_q;
  assign dr_value_o = dr_q;

  // serial out from whichever chain is shifting
  assign tdo_o = shift_ir_i ? ir_q[0] : dr_q[0];

endmodule

`default_nettype wire

// File: source/had_dbg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module had_dbg_regs
  import had_jtag_pkg::*;
  import had_dbg_pkg::*;
#(
  parameter logic [DR_WIDTH-1:0] ID_VALUE   = '0,
  parameter int                  FIFO_DEPTH = 4
)
(
  input  wire                 sm_clk,
  input  wire                 cpurst_b,
  input  wire                 upd_ir_pulse_i,
  input  wire                 upd_dr_pulse_i,
  input  wire  [IR_WIDTH-1:0] ir_value_i,
  input  wire  [DR_WIDTH-1:0] dr_value_i,
  input  wire                 fifo_push_i,
  input  wire  [DR_WIDTH-1:0] fifo_data_i,
  output logic                hacr_rw_o,
  output logic [DR_WIDTH-1:0] rd_data_o,
  output logic [DR_WIDTH-1:0] ctrl_o,
  output logic                fifo_full_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = FIFO_DEPTH[PTR_W:0];

  hacr_u               hacr_q;
  logic [DR_WIDTH-1:0] fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [PTR_W:0]      count_q;
  logic                fifo_empty;
  logic                ctrl_wr;
  logic                push_ok;
  logic                pop_ok;

  // ============================================================
  // HACR and control register
  // ============================================================
  always_ff @(posedge sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      hacr_q.raw <= HACR_RESET;
    else if (upd_ir_pulse_i)
      hacr_q.raw <= ir_value_i;
  end

  assign hacr_rw_o = hacr_q.fld.rw;

  // write access to the control select
  assign ctrl_wr = upd_dr_pulse_i && !hacr_q.fld.rw && (hacr_q.fld.reg_sel == SEL_CTRL);

  always_ff @(posedge sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ctrl_o <= CTRL_RESET;
    else if (ctrl_wr)
      ctrl_o <= dr_value_i;
  end

  // ============================================================
  // debug FIFO
  // ============================================================
  assign fifo_empty  = (count_q == '0);
  assign fifo_full_o = (count_q == FULL_COUNT);

  // push when full is dropped
  assign push_ok = fifo_push_i && !fifo_full_o;
  // pop of the head that the last DR capture took
  // ignored when nothing is stored
  assign pop_ok  = upd_dr_pulse_i && hacr_q.fld.rw &&
                   (hacr_q.fld.reg_sel == SEL_FIFO) && !fifo_empty;

  always_ff @(posedge sm_clk)
  begin
    if (push_ok)
      fifo_mem[wr_ptr_q] <= fifo_data_i;
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_ok)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ============================================================
  // read data toward the DR capture
  // ============================================================
  always_comb
  begin
    case (hacr_q.fld.reg_sel)
      SEL_ID:   rd_data_o = ID_VALUE;
      SEL_CTRL: rd_data_o = ctrl_o;
      // empty fifo reads as zero
      SEL_FIFO: rd_data_o = fifo_empty ? '0 : fifo_mem[rd_ptr_q];
      default:  rd_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/had_top.sv
`timescale 1ns/1ps
`default_nettype none

module had_top
  import had_jtag_pkg::*;
#(
  parameter logic [DR_WIDTH-1:0] ID_VALUE   = '0,
  parameter int                  FIFO_DEPTH = 4
)
(
  input  wire                sm_clk,
  input  wire                cpurst_b,
  input  wire                tclk_i,
  input  wire                trst_b_i,
  input  wire                tms_i,
  input  wire                tdi_i,
  input  wire                tap_en_i,
  output wire                tdo_o,
  output wire                tdo_en_o,
  input  wire                fifo_push_i,
  input  wire [DR_WIDTH-1:0] fifo_data_i,
  output wire                fifo_full_o,
  output wire [DR_WIDTH-1:0] ctrl_o
);

  // tclk domain strobes
  wire                shift_ir;
  wire                shift_dr;
  wire                capture_ir;
  wire                capture_dr;
  // sm_clk domain update enables
  wire                upd_ir_pulse;
  wire                upd_dr_pulse;
  // scan chain and register block exchange
  wire [IR_WIDTH-1:0] ir_value;
  wire [DR_WIDTH-1:0] dr_value;
  wire [DR_WIDTH-1:0] rd_data;
  wire                hacr_rw;

  // ============================================================
  // TAP controller and update sync
  // ============================================================
  had_tap_sm u_tap_sm (
    .sm_clk         (sm_clk),
    .cpurst_b       (cpurst_b),
    .tclk_i         (tclk_i),
    .trst_b_i       (trst_b_i),
    .tms_i          (tms_i),
    .tap_en_i       (tap_en_i),
    .hacr_rw_i      (hacr_rw),
    .shift_ir_o     (shift_ir),
    .shift_dr_o     (shift_dr),
    .capture_ir_o   (capture_ir),
    .capture_dr_o   (capture_dr),
    .upd_ir_pulse_o (upd_ir_pulse),
    .upd_dr_pulse_o (upd_dr_pulse),
    .tdo_en_o       (tdo_en_o)
  );

  // IR and DR shift registers
  had_scan_chain u_scan_chain (
    .tclk_i       (tclk_i),
    .trst_b_i     (trst_b_i),
    .tdi_i        (tdi_i),
    .shift_ir_i   (shift_ir),
    .shift_dr_i   (shift_dr),
    .capture_ir_i (capture_ir),
    .capture_dr_i (capture_dr),
    .rd_data_i    (rd_data),
    .ir_value_o   (ir_value),
    .dr_value_o   (dr_value),
    .tdo_o        (tdo_o)
  );

  // ============================================================
  // sm_clk register block
  // ============================================================
  had_dbg_regs #(
    .ID_VALUE   (ID_VALUE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dbg_regs (
    .sm_clk         (sm_clk),
    .cpurst_b       (cpurst_b),
    .upd_ir_pulse_i (upd_ir_pulse),
    .upd_dr_pulse_i (upd_dr_pulse),
    .ir_value_i     (ir_value),
    .dr_value_i     (dr_value),
    .fifo_push_i    (fifo_push_i),
    .fifo_data_i    (fifo_data_i),
    .hacr_rw_o      (hacr_rw),
    .rd_data_o      (rd_data),
    .ctrl_o         (ctrl_o),
    .fifo_full_o    (fifo_full_o)
  );

endmodule

`default_nettype wire

// File: include/had_tb_jtag_tasks.svh
`ifndef HAD_TB_JTAG_TASKS_SVH
`define HAD_TB_JTAG_TASKS_SVH

// ============================================================
// jtag host side
// ============================================================
// tms set here is seen on the following rising tclk
task automatic tms_step(input logic tms_v);
  @(posedge tclk_i);
  tms_i <= tms_v;
endtask

// shift phase shared by IR and DR scans
// starts on the edge that leaves the capture state
task automatic shift_bits(
  input  int                  nbits,
  input  logic [DR_WIDTH-1:0] din,
  output logic [DR_WIDTH-1:0] dout,
  output int                  en_cycles
);
  dout      = '0;
  en_cycles = 0;
  @(posedge tclk_i);
  // first bit for the first shift edge
  tdi_i <= din[0];
  tms_i <= (nbits == 1);
  for (int i = 0; i < nbits; i++)
  begin
    @(posedge tclk_i);
    // flop outputs still hold pre-edge values here
    dout[i] = tdo_o;
    if (tdo_en_o)
      en_cycles++;
    if (i + 1 < nbits)
    begin
      tdi_i <= din[i+1];
      // last bit leaves shift for exit1
      tms_i <= (i + 2 == nbits);
    end
    else
      // exit1 to update
      tms_i <= 1'b1;
  end
  // update to idle and one more idle cycle
  tms_step(1'b0);
  tms_step(1'b0);
  tms_step(1'b0);
  // room for the synced update pulse in sm_clk
  repeat (8) @(posedge sm_clk);
endtask

// idle, select-dr, capture-dr, shift
task automatic dr_scan(
  input  logic [DR_WIDTH-1:0] din,
  output logic [DR_WIDTH-1:0] dout,
  output int                  en_cycles
);
  tms_step(1'b1);
  tms_step(1'b0);
  tms_step(1'b0);
  shift_bits(DR_WIDTH, din, dout, en_cycles);
endtask

// idle, select-dr, select-ir, capture-ir, shift
// captured IR pattern 8'h01 comes out first
task automatic ir_scan(input logic [IR_WIDTH-1:0] hacr);
  logic [DR_WIDTH-1:0] ir_out;
  int                  ir_en;
  tms_step(1'b1);
  tms_step(1'b1);
  tms_step(1'b0);
  tms_step(1'b0);
  shift_bits(IR_WIDTH, {{(DR_WIDTH-IR_WIDTH){1'b0}}, hacr}, ir_out, ir_en);
  check_value("tdo_o during IR shift", ir_out, 32'h0000_0001);
  check_value("tdo_en_o during IR shift", ir_en, 0);
endtask

`endif

// File: test/had_tb.sv
`timescale 1ns/1ps
`default_nettype none

module had_tb
  import had_jtag_pkg::*;
  import had_dbg_pkg::*;
();

  localparam logic [DR_WIDTH-1:0] ID_WORD = 32'h1A2B3C4D;
  localparam int                  DEPTH   = 4;

  // scan lengths in tclk cycles
  // tms walk, capture, shift, exit/update/idle
  localparam int DR_SCAN_TCK = 3 + 1 + DR_WIDTH + 3;
  localparam int IR_SCAN_TCK = 4 + 1 + IR_WIDTH + 3;
  // one tclk is five sm_clk
  // each scan settles for 8 sm_clk
  // ten DR scans and five IR scans over the whole run
  localparam int SCAN_BUDGET = 10 * (DR_SCAN_TCK * 5 + 8) + 5 * (IR_SCAN_TCK * 5 + 8);
  localparam int TIMEOUT_CYCLES = 2 * SCAN_BUDGET + 200;

  logic                sm_clk = 1'b0;
  logic                tclk_i = 1'b0;
  logic                cpurst_b;
  logic                trst_b_i;
  logic                tms_i;
  logic                tdi_i;
  logic                tap_en_i;
  logic                fifo_push_i;
  logic [DR_WIDTH-1:0] fifo_data_i;
  wire                 tdo_o;
  wire                 tdo_en_o;
  wire                 fifo_full_o;
  wire  [DR_WIDTH-1:0] ctrl_o;

  int                  err_cnt = 0;
  int                  test_cnt = 0;
  int                  test_fail_cnt = 0;
  int                  test_err_base = 0;
  int                  cycle_cnt = 0;
  int                  en_cnt;
  logic [DR_WIDTH-1:0] scan_out;
  logic [DR_WIDTH-1:0] word;
  // last word written to the control register
  logic [DR_WIDTH-1:0] ctrl_exp;
  // reference copy of what the debug FIFO should hold
  logic [DR_WIDTH-1:0] fifo_model [$];

  had_top #(
    .ID_VALUE   (ID_WORD),
    .FIFO_DEPTH (DEPTH)
  ) DUT (
    .sm_clk      (sm_clk),
    .cpurst_b    (cpurst_b),
    .tclk_i      (tclk_i),
    .trst_b_i    (trst_b_i),
    .tms_i       (tms_i),
    .tdi_i       (tdi_i),
    .tap_en_i    (tap_en_i),
    .tdo_o       (tdo_o),
    .tdo_en_o    (tdo_en_o),
    .fifo_push_i (fifo_push_i),
    .fifo_data_i (fifo_data_i),
    .fifo_full_o (fifo_full_o),
    .ctrl_o      (ctrl_o)
  );

  // ============================================================
  // clocks and run limit
  // ============================================================
  always #2 sm_clk = ~sm_clk;
  // jtag clock with a 20 ns period
  always #10 tclk_i = ~tclk_i;

  always @(posedge sm_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout, run did not end within %0d sm_clk cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // compare one value against its expected word
  task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %s got 32'h%08h expected 32'h%08h", sig, got, exp);
      err_cnt++;
    end
  endtask

  // one line per finished test
  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base)
      $display("test %0d %s ok", test_cnt, name);
    else
    begin
      test_fail_cnt++;
      $display("test %0d %s failed with %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // system side push of one word per sm_clk
  task automatic push_word(input logic [DR_WIDTH-1:0] w);
    @(posedge sm_clk);
    fifo_push_i <= 1'b1;
    fifo_data_i <= w;
  endtask

  `include "had_tb_jtag_tasks.svh"

  // ============================================================
  // stimulus sequence
  // ============================================================
  initial
  begin
    cpurst_b    = 1'b0;
    trst_b_i    = 1'b0;
    tms_i       = 1'b1;
    tdi_i       = 1'b0;
    tap_en_i    = 1'b1;
    fifo_push_i = 1'b0;
    fifo_data_i = '0;
    ctrl_exp    = '0;
    void'($urandom(32'h6929));
    repeat (5) @(posedge sm_clk);
    cpurst_b <= 1'b1;
    @(posedge tclk_i);
    trst_b_i <= 1'b1;
    // out of test logic reset into idle
    tms_step(1'b0);
    tms_step(1'b0);

    // values straight after reset
    check_value("tdo_en_o", tdo_en_o, 0);
    check_value("ctrl_o", ctrl_o, 0);
    check_value("fifo_full_o", fifo_full_o, 0);
    finish_test("reset values");

    // default HACR is a read of the ID word
    dr_scan('0, scan_out, en_cnt);
    check_value("tdo_o ID word", scan_out, ID_WORD);
    check_value("tdo_en_o high cycles", en_cnt, DR_WIDTH);
    finish_test("default ID read");

    // control register write then read back
    ir_scan({1'b0, SEL_CTRL});
    word = $urandom;
    dr_scan(word, scan_out, en_cnt);
    ctrl_exp = word;
    check_value("ctrl_o", ctrl_o, ctrl_exp);
    check_value("tdo_en_o high cycles", en_cnt, 0);
    ir_scan({1'b1, SEL_CTRL});
    dr_scan('0, scan_out, en_cnt);
    check_value("tdo_o ctrl word", scan_out, ctrl_exp);
    check_value("tdo_en_o high cycles", en_cnt, DR_WIDTH);
    check_value("ctrl_o", ctrl_o, ctrl_exp);
    finish_test("ctrl write and read");

    // fill the FIFO plus one extra push past full
    for (int i = 0; i < DEPTH + 1; i++)
    begin
      word = $urandom;
      push_word(word);
      if (fifo_model.size() < DEPTH)
        fifo_model.push_back(word);
    end
    @(posedge sm_clk);
    fifo_push_i <= 1'b0;
    @(posedge sm_clk);
    check_value("fifo_full_o", fifo_full_o, 1);
    ir_scan({1'b1, SEL_FIFO});
    for (int i = 0; i < DEPTH; i++)
    begin
      dr_scan('0, scan_out, en_cnt);
      word = fifo_model.pop_front();
      check_value("tdo_o fifo word", scan_out, word);
      check_value("fifo_full_o", fifo_full_o, 0);
    end
    // drained fifo reads as zero
    dr_scan('0, scan_out, en_cnt);
    check_value("tdo_o empty fifo", scan_out, 0);
    check_value("fifo_full_o", fifo_full_o, 0);
    finish_test("fifo push and pop");

    // write with the port disabled must not land
    ir_scan({1'b0, SEL_CTRL});
    @(posedge tclk_i);
    tap_en_i <= 1'b0;
    word = $urandom;
    dr_scan(word, scan_out, en_cnt);
    check_value("ctrl_o", ctrl_o, ctrl_exp);
    check_value("tdo_en_o high cycles", en_cnt, 0);
    @(posedge tclk_i);
    tap_en_i <= 1'b1;
    // five ones reach reset from any state
    repeat (5) tms_step(1'b1);
    @(posedge tclk_i);
    tms_i <= 1'b0;
    @(negedge tclk_i);
    check_value("tap state", DUT.u_tap_sm.state_q, TAP_RESET);
    ir_scan({1'b0, SEL_CTRL});
    word = $urandom;
    dr_scan(word, scan_out, en_cnt);
    ctrl_exp = word;
    check_value("ctrl_o", ctrl_o, ctrl_exp);
    check_value("tdo_en_o high cycles", en_cnt, 0);
    finish_test("tap disable and reset");

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
source/had_jtag_pkg.sv
source/had_dbg_pkg.sv
source/had_sync_3flop.sv
source/had_tap_sm.sv
source/had_scan_chain.sv
source/had_dbg_regs.sv
source/had_top.sv
test/had_tb.sv

// File: Bender.yml
package:
  name: had_jtag_dap

sources:
  - source/had_jtag_pkg.sv
  - source/had_dbg_pkg.sv
  - source/had_sync_3flop.sv
  - source/had_tap_sm.sv
  - source/had_scan_chain.sv
  - source/had_dbg_regs.sv
  - source/had_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/had_tb.sv
